//--- common/i2c_cmd_pkg.sv
// host-side command and read-stream types, imported by the I2C master and its controller
`default_nettype none

package i2c_cmd_pkg;

    // 7-bit slave address
    localparam int addr_w = 7;
    localparam int byte_w = 8;

    typedef logic [addr_w-1:0] i2c_addr_t;

    // one host command word
    typedef struct packed {
        logic      stop;
        logic      write;
        logic      read;
        logic      start;
        i2c_addr_t addr;
    } i2c_cmd_t;

    // byte returned by a read, last marks the byte that ended with NACK and stop
    typedef struct packed {
        logic [byte_w-1:0] data;
        logic              last;
    } i2c_rd_t;

endpackage

`default_nettype wire

//--- common/i2c_phy_pkg.sv
// bit-level operation codes and counter widths shared by the controller and the bit engine
`default_nettype none

package i2c_phy_pkg;

    // quarter SCL period in clk cycles, minus one
    localparam int prescale_w = 16;

    // one bit wider than prescale
    localparam int delay_w = 17;

    // counts 8 down to 0
    localparam int bit_cnt_w = 4;

    // single-cycle request from controller to bit engine
    typedef enum logic [2:0] {
        op_none,
        op_start,
        op_stop,
        op_write,
        op_read
    } phy_op_e;

endpackage

`default_nettype wire

//--- hw/i2c_bus_monitor.sv
// synchronizes the I2C pins and tracks bus activity from start and stop conditions
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_monitor (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic scl_i,
    input  wire logic sda_i,
    output logic      scl_s,
    output logic      sda_s,
    output logic      bus_active
);

logic scl_m, sda_m, sda_last;

always_ff @(posedge clk) begin
    if (rst) begin
        scl_m <= 1'b1;
        sda_m <= 1'b1;
        scl_s <= 1'b1;
        sda_s <= 1'b1;
        sda_last <= 1'b1;
        bus_active <= 1'b0;
    end else begin
        // two-flop synchronizer
        scl_m <= scl_i;
        sda_m <= sda_i;
        scl_s <= scl_m;
        sda_s <= sda_m;
        sda_last <= sda_s;
        // SDA edge with SCL high is start or stop
        if (scl_s && sda_last && !sda_s) begin
            bus_active <= 1'b1;
        end else if (scl_s && !sda_last && sda_s) begin
            bus_active <= 1'b0;
        end
    end
end

endmodule

`default_nettype wire

//--- hw/i2c_byte_shift.sv
// byte shift register with bit counter for the address, write and read phases of the I2C master
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_shift
    import i2c_cmd_pkg::*, i2c_phy_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              load,
    input  wire logic [byte_w-1:0] load_byte,
    input  wire logic              shift,
    input  wire logic              in_bit,
    output logic                   out_bit,
    output logic [byte_w-1:0]      byte_q,
    output logic                   empty
);

logic [bit_cnt_w-1:0] cnt;

// MSB leaves first, new bits enter at the LSB
always_ff @(posedge clk) begin
    if (load) begin
        byte_q <= load_byte;
    end else if (shift) begin
        byte_q <= {byte_q[byte_w-2:0], in_bit};
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        cnt <= '0;
    end else if (load) begin
        cnt <= bit_cnt_w'(byte_w);
    end else if (shift) begin
        cnt <= cnt - 1'b1;
    end
end

assign out_bit = byte_q[byte_w-1];
assign empty = (cnt == '0);

no_shift_empty: assert property (@(posedge clk) disable iff (rst) shift |-> !empty);

endmodule

`default_nettype wire

//--- hw/i2c_ctrl.sv
// transaction FSM of the I2C master, turns host commands into bit engine operations
`timescale 1ns/1ps
`default_nettype none

module i2c_ctrl
    import i2c_cmd_pkg::*, i2c_phy_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire i2c_cmd_t          cmd,
    input  wire logic              cmd_valid,
    output logic                   cmd_ready,
    input  wire logic [byte_w-1:0] wr_data,
    input  wire logic              wr_valid,
    output logic                   wr_ready,
    output i2c_rd_t                rd,
    output logic                   rd_valid,
    input  wire logic              rd_ready,
    input  wire logic              bus_active,
    output phy_op_e                phy_op,
    output logic                   phy_tx_bit,
    input  wire logic              phy_ready,
    input  wire logic              phy_rx_bit,
    output logic                   load,
    output logic [byte_w-1:0]      load_byte,
    output logic                   shift,
    input  wire logic              out_bit,
    input  wire logic [byte_w-1:0] byte_q,
    input  wire logic              empty,
    output logic                   missed_ack
);

typedef enum logic [3:0] {
    st_idle, st_active_wr, st_active_rd, st_start_wait, st_start, st_addr, st_addr_ack,
    st_write, st_write_bits, st_write_ack, st_read, st_read_bit, st_stop
} state_e;

state_e    state, state_next;
i2c_addr_t addr_q;
logic      read_q, stop_q, nack_q;
logic      latch, present;
logic      cmd_ready_next, wr_ready_next, rd_valid_next, missed_ack_next;
logic      take_cmd, xfer, stop_only;

assign take_cmd = cmd_ready && cmd_valid;
assign xfer = cmd.read ^ cmd.write;
assign stop_only = cmd.stop && !cmd.read && !cmd.write;

always_comb begin
    state_next = state;
    phy_op = op_none;
    phy_tx_bit = out_bit;
    load = 1'b0;
    load_byte = {addr_q, read_q};
    shift = 1'b0;
    latch = 1'b0;
    present = 1'b0;
    cmd_ready_next = 1'b0;
    wr_ready_next = 1'b0;
    rd_valid_next = rd_valid && !rd_ready;
    missed_ack_next = 1'b0;
    // everything waits for the bit engine
    if (phy_ready) begin
        case (state)
            st_idle: begin
                cmd_ready_next = !(take_cmd && xfer);
                latch = take_cmd && xfer;
                if (take_cmd && xfer) begin
                    state_next = st_start_wait;
                end
            end
            st_active_wr, st_active_rd: begin
                // bus held by us, SCL low
                cmd_ready_next = (state == st_active_wr) || !rd_valid;
                if (take_cmd && (xfer || stop_only)) begin
                    cmd_ready_next = 1'b0;
                    latch = xfer;
                    if (state == st_active_rd) begin
                        // ACK only when the next read continues this transfer
                        phy_op = op_write;
                        phy_tx_bit = 1'b1;
                    end
                    if (stop_only) begin
                        phy_op = (state == st_active_rd) ? op_write : op_stop;
                        state_next = (state == st_active_rd) ? st_stop : st_idle;
                    end else if (cmd.start || cmd.addr != addr_q || cmd.read != read_q) begin
                        state_next = st_start;
                    end else if (read_q) begin
                        phy_tx_bit = 1'b0;
                        load = 1'b1;
                        load_byte = '0;
                        state_next = st_read;
                    end else begin
                        wr_ready_next = 1'b1;
                        state_next = st_write;
                    end
                end
            end
            st_start_wait, st_start: begin
                // a repeated start skips the idle-bus wait
                if (state == st_start || !bus_active) begin
                    phy_op = op_start;
                    load = 1'b1;
                    state_next = st_addr;
                end
            end
            st_addr, st_write_bits: begin
                if (!empty) begin
                    phy_op = op_write;
                    shift = 1'b1;
                end else begin
                    phy_op = op_read;
                    state_next = (state == st_addr) ? st_addr_ack : st_write_ack;
                end
            end
            st_addr_ack: begin
                missed_ack_next = phy_rx_bit;
                load = read_q;
                load_byte = '0;
                wr_ready_next = !read_q;
                state_next = read_q ? st_read : st_write;
            end
            st_write: begin
                wr_ready_next = !(wr_ready && wr_valid);
                if (wr_ready && wr_valid) begin
                    // absent slave, byte is dropped and the bus released
                    load = !nack_q;
                    load_byte = wr_data;
                    phy_op = nack_q ? op_stop : op_none;
                    state_next = nack_q ? st_idle : st_write_bits;
                end
            end
            st_write_ack: begin
                missed_ack_next = phy_rx_bit;
                phy_op = stop_q ? op_stop : op_none;
                state_next = stop_q ? st_idle : st_active_wr;
            end
            st_read: begin
                if (!empty) begin
                    phy_op = op_read;
                    state_next = st_read_bit;
                end else begin
                    present = 1'b1;
                    rd_valid_next = 1'b1;
                    if (stop_q) begin
                        // NACK the final byte
                        phy_op = op_write;
                        phy_tx_bit = 1'b1;
                        state_next = st_stop;
                    end else begin
                        state_next = st_active_rd;
                    end
                end
            end
            st_read_bit: begin
                shift = 1'b1;
                state_next = st_read;
            end
            st_stop: begin
                phy_op = op_stop;
                state_next = st_idle;
            end
            default: state_next = st_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= st_idle;
        cmd_ready <= 1'b0;
        wr_ready <= 1'b0;
        rd_valid <= 1'b0;
        missed_ack <= 1'b0;
    end else begin
        state <= state_next;
        cmd_ready <= cmd_ready_next;
        wr_ready <= wr_ready_next;
        rd_valid <= rd_valid_next;
        missed_ack <= missed_ack_next;
    end
end

always_ff @(posedge clk) begin
    if (latch) begin
        addr_q <= cmd.addr;
        read_q <= cmd.read;
        stop_q <= cmd.stop;
    end
    if (present) begin
        rd.data <= byte_q;
        rd.last <= stop_q;
    end
    if (state == st_addr_ack && phy_ready) begin
        nack_q <= phy_rx_bit;
    end
end

// each op request lasts a single cycle
op_pulse: assert property (@(posedge clk) disable iff (rst)
    (phy_op != op_none) |=> (phy_op == op_none));

endmodule

`default_nettype wire

//--- hw/i2c_master.sv
// I2C bus master top level, joins the transaction FSM, bit engine, byte shifter and bus monitor
`timescale 1ns/1ps
`default_nettype none

module i2c_master
    import i2c_cmd_pkg::*, i2c_phy_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire i2c_cmd_t              cmd,
    input  wire logic                  cmd_valid,
    output wire logic                  cmd_ready,
    input  wire logic [byte_w-1:0]     wr_data,
    input  wire logic                  wr_valid,
    output wire logic                  wr_ready,
    output wire i2c_rd_t               rd,
    output wire logic                  rd_valid,
    input  wire logic                  rd_ready,
    // open drain, 1 releases the line
    input  wire logic                  scl_i,
    input  wire logic                  sda_i,
    output wire logic                  scl_o,
    output wire logic                  sda_o,
    output wire logic                  bus_control,
    output wire logic                  bus_active,
    output wire logic                  missed_ack,
    input  wire logic [prescale_w-1:0] prescale
);

phy_op_e           phy_op;
logic              phy_tx_bit, phy_ready, phy_rx_bit;
logic              load, shift, out_bit, empty;
logic [byte_w-1:0] load_byte, byte_q;
logic              scl_s, sda_s;

i2c_ctrl u_ctrl (
    .clk, .rst,
    .cmd, .cmd_valid, .cmd_ready,
    .wr_data, .wr_valid, .wr_ready,
    .rd, .rd_valid, .rd_ready,
    .bus_active,
    .phy_op, .phy_tx_bit, .phy_ready, .phy_rx_bit,
    .load, .load_byte, .shift, .out_bit, .byte_q, .empty,
    .missed_ack
);

i2c_bit_phy u_phy (
    .clk, .rst,
    .op(phy_op), .tx_bit(phy_tx_bit), .ready(phy_ready), .rx_bit(phy_rx_bit),
    .scl_s, .sda_s, .scl_o, .sda_o,
    .bus_control, .prescale
);

// rx bits enter at the LSB during reads
i2c_byte_shift u_shift (
    .clk, .rst,
    .load, .load_byte, .shift, .in_bit(phy_rx_bit),
    .out_bit, .byte_q, .empty
);

i2c_bus_monitor u_mon (
    .clk, .rst,
    .scl_i, .sda_i, .scl_s, .sda_s, .bus_active
);

endmodule

`default_nettype wire

//--- i2c_phy/i2c_bit_phy.sv
// I2C bit engine, times SCL and SDA for start, stop, write-bit and read-bit with clock stretching
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_phy
    import i2c_phy_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire phy_op_e               op,
    input  wire logic                  tx_bit,
    output logic                       ready,
    output logic                       rx_bit,
    input  wire logic                  scl_s,
    input  wire logic                  sda_s,
    output logic                       scl_o,
    output logic                       sda_o,
    output logic                       bus_control,
    input  wire logic [prescale_w-1:0] prescale
);

typedef enum logic [3:0] {
    ph_idle, ph_active, ph_rstart_1, ph_rstart_2, ph_start_1, ph_start_2,
    ph_write_1, ph_write_2, ph_write_3, ph_read_1, ph_read_2, ph_read_3, ph_read_4,
    ph_stop_1, ph_stop_2, ph_stop_3
} ph_state_e;

ph_state_e          state;
logic [delay_w-1:0] delay, period;
logic               stretch;

assign period = delay_w'(prescale);
assign ready = (state == ph_idle || state == ph_active) && delay == '0 && !stretch;

always_ff @(posedge clk) begin
    if (rst) begin
        state <= ph_idle;
        delay <= '0;
        stretch <= 1'b0;
        scl_o <= 1'b1;
        sda_o <= 1'b1;
        bus_control <= 1'b0;
    end else if (stretch) begin
        // slave holding SCL low
        stretch <= scl_o && !scl_s;
    end else if (delay != '0) begin
        delay <= delay - 1'b1;
    end else begin
        // every phase but the closing cycle lasts one period
        delay <= period;
        case (state)
            ph_idle: begin
                delay <= (op == op_start) ? period : '0;
                if (op == op_start) begin
                    sda_o <= 1'b0;
                    state <= ph_start_1;
                end
            end
            ph_active: begin
                delay <= (op == op_none) ? '0 : period;
                sda_o <= (op == op_write) ? tx_bit : (op != op_stop);
                case (op)
                    op_start: state <= ph_rstart_1;
                    op_write: state <= ph_write_1;
                    op_read:  state <= ph_read_1;
                    op_stop:  state <= ph_stop_1;
                    default:  sda_o <= sda_o;
                endcase
            end
            ph_rstart_1, ph_write_1, ph_read_1, ph_stop_1: begin
                scl_o <= 1'b1;
                stretch <= 1'b1;
                state <= (state == ph_rstart_1) ? ph_rstart_2 :
                         (state == ph_write_1) ? ph_write_2 :
                         (state == ph_read_1) ? ph_read_2 : ph_stop_2;
            end
            ph_rstart_2: begin
                sda_o <= 1'b0;
                state <= ph_start_1;
            end
            ph_start_1, ph_write_2, ph_read_3: begin
                scl_o <= 1'b0;
                state <= (state == ph_start_1) ? ph_start_2 :
                         (state == ph_write_2) ? ph_write_3 : ph_read_4;
            end
            ph_read_2: begin
                // mid-high sample
                rx_bit <= sda_s;
                state <= ph_read_3;
            end
            ph_stop_2: begin
                sda_o <= 1'b1;
                state <= ph_stop_3;
            end
            ph_start_2, ph_write_3, ph_read_4: begin
                delay <= '0;
                bus_control <= 1'b1;
                state <= ph_active;
            end
            default: begin
                delay <= '0;
                bus_control <= 1'b0;
                state <= ph_idle;
            end
        endcase
    end
end

// only start and stop move SDA while SCL is high
sda_stable_high: assert property (@(posedge clk) disable iff (rst)
    (scl_o && $past(scl_o) && sda_o != $past(sda_o)) |-> state inside {ph_start_1, ph_stop_3});

op_accept: assert property (@(posedge clk) disable iff (rst) (op != op_none) |-> ready);

endmodule

`default_nettype wire

//--- sim.f
common/i2c_cmd_pkg.sv
common/i2c_phy_pkg.sv
i2c_phy/i2c_bit_phy.sv
hw/i2c_byte_shift.sv
hw/i2c_bus_monitor.sv
hw/i2c_ctrl.sv
hw/i2c_master.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

//--- test/i2c_slave_model.sv
// behavioral I2C slave for the testbench, answers one address, keeps written bytes and logs bus events
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] dev_addr = 7'h50
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       scl,
    input  wire logic       sda,
    input  wire logic [7:0] stretch_len,
    output logic            scl_drive,
    output logic            sda_drive
);

logic       scl_q, sda_q;
logic [3:0] cnt;
logic [7:0] shreg, tx_byte, stretch_left;
logic       in_xfer, is_addr, selected, sending, master_ack;
logic [7:0] mem [0:15];
int         wr_cnt, rd_ptr, start_cnt, stop_cnt, rstart_cnt, stretches;

// next byte of the store, or the inverse of the newest one once all were read
task automatic load_tx();
    logic [7:0] b;
    if (rd_ptr < wr_cnt) begin
        b = mem[rd_ptr];
        rd_ptr <= rd_ptr + 1;
    end else if (wr_cnt == 0) begin
        b = 8'hff;
    end else begin
        b = ~mem[wr_cnt-1];
    end
    tx_byte <= b;
    sda_drive <= b[7];
endtask

always @(posedge clk) begin
    if (rst) begin
        scl_q <= 1'b1;
        sda_q <= 1'b1;
        scl_drive <= 1'b1;
        sda_drive <= 1'b1;
        cnt <= '0;
        stretch_left <= '0;
        in_xfer <= 1'b0;
        is_addr <= 1'b0;
        selected <= 1'b0;
        sending <= 1'b0;
        wr_cnt <= 0;
        rd_ptr <= 0;
        start_cnt <= 0;
        stop_cnt <= 0;
        rstart_cnt <= 0;
        stretches <= 0;
    end else begin
        scl_q <= scl;
        sda_q <= sda;
        if (stretch_left != 0) begin
            stretch_left <= stretch_left - 1'b1;
            scl_drive <= (stretch_left == 8'd1);
        end
        if (scl && scl_q && sda_q && !sda) begin
            // start, repeated when no stop came first
            start_cnt <= start_cnt + 1;
            if (in_xfer) begin
                rstart_cnt <= rstart_cnt + 1;
            end
            in_xfer <= 1'b1;
            is_addr <= 1'b1;
            selected <= 1'b0;
            sending <= 1'b0;
            cnt <= '0;
            sda_drive <= 1'b1;
        end else if (scl && scl_q && !sda_q && sda) begin
            stop_cnt <= stop_cnt + 1;
            in_xfer <= 1'b0;
            is_addr <= 1'b0;
            selected <= 1'b0;
            sending <= 1'b0;
            cnt <= '0;
            sda_drive <= 1'b1;
        end else if (scl && !scl_q && (is_addr || selected)) begin
            if (cnt < 4'd8 && !sending) begin
                shreg <= {shreg[6:0], sda};
            end
            if (cnt == 4'd8 && sending) begin
                master_ack <= !sda;
            end
            cnt <= cnt + 1'b1;
        end else if (!scl && scl_q && (is_addr || selected)) begin
            if (cnt == 4'd8) begin
                if (sending) begin
                    // master owns the acknowledge bit
                    sda_drive <= 1'b1;
                end else if (is_addr) begin
                    sda_drive <= (shreg[7:1] != dev_addr);
                end else begin
                    mem[wr_cnt] <= shreg;
                    wr_cnt <= wr_cnt + 1;
                    sda_drive <= 1'b0;
                end
            end else if (cnt == 4'd9) begin
                cnt <= '0;
                sda_drive <= 1'b1;
                if (is_addr) begin
                    is_addr <= 1'b0;
                    selected <= (shreg[7:1] == dev_addr);
                    sending <= shreg[0];
                    if (shreg[7:1] == dev_addr && shreg[0]) begin
                        load_tx();
                    end
                end else if (sending && master_ack) begin
                    load_tx();
                end else if (sending) begin
                    // NACK ends the read, wait for stop or start
                    selected <= 1'b0;
                    sending <= 1'b0;
                end
            end else if (sending) begin
                sda_drive <= tx_byte[7 - cnt];
            end else if (!is_addr && cnt == 4'd4 && stretch_len != 0) begin
                // hold SCL low in the middle of a data byte
                stretch_left <= stretch_len;
                scl_drive <= 1'b0;
                stretches <= stretches + 1;
            end
        end
    end
end

endmodule

`default_nettype wire

//--- test/tb_i2c_master.sv
// testbench for the I2C master, runs host transfers against a slave model on a wired-AND bus
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master
    import i2c_cmd_pkg::*, i2c_phy_pkg::*;
();

localparam int prescale_val = 2;
// 8 transfers of 12 bits, 4 phases per bit, margin of 4
localparam int max_cycles = 8 * 12 * 4 * (prescale_val + 1) * 4;

logic                  clk = 1'b0;
logic                  rst;
i2c_cmd_t              cmd;
logic                  cmd_valid, cmd_ready;
logic [byte_w-1:0]     wr_data;
logic                  wr_valid, wr_ready;
i2c_rd_t               rd;
logic                  rd_valid, rd_ready;
logic                  scl_o, sda_o, scl_drive, sda_drive, scl_bus, sda_bus;
logic                  bus_control, bus_active, missed_ack;
logic [prescale_w-1:0] prescale;
logic [7:0]            stretch_len;

logic [7:0] exp_wr [0:15];
int         exp_wr_cnt, rd_idx, miss_cnt, cycles;
int         errors, test_errors, tests_run, tests_failed;
logic       exp_last;
string      cur_test;

// open-drain bus
assign scl_bus = scl_o & scl_drive;
assign sda_bus = sda_o & sda_drive;

always #2 clk = ~clk;

i2c_master dut_i (
    .clk, .rst,
    .cmd, .cmd_valid, .cmd_ready,
    .wr_data, .wr_valid, .wr_ready,
    .rd, .rd_valid, .rd_ready,
    .scl_i(scl_bus), .sda_i(sda_bus), .scl_o, .sda_o,
    .bus_control, .bus_active, .missed_ack, .prescale
);

i2c_slave_model #(.dev_addr(7'h50)) slave_i (
    .clk, .rst, .scl(scl_bus), .sda(sda_bus), .stretch_len, .scl_drive, .sda_drive
);

// stored bytes in write order, then the inverse of the newest one
function automatic logic [7:0] exp_read(input int idx);
    if (idx < exp_wr_cnt) begin
        return exp_wr[idx];
    end else if (exp_wr_cnt == 0) begin
        return 8'hff;
    end
    return ~exp_wr[exp_wr_cnt-1];
endfunction

task automatic check_val(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
        $display("** Error in test %s, %s: expected %0h, actual %0h",
                 cur_test, name, expected, actual);
        errors++;
        test_errors++;
    end
endtask

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic send_cmd(input logic [6:0] addr, input logic start, read, write, stop);
    cmd.addr = addr;
    cmd.start = start;
    cmd.read = read;
    cmd.write = write;
    cmd.stop = stop;
    cmd_valid = 1'b1;
    while (!cmd_ready) next_cycle();
    next_cycle();
    cmd_valid = 1'b0;
endtask

task automatic write_xfer(input logic [6:0] addr, input logic stop, input logic [7:0] b);
    send_cmd(addr, 1'b0, 1'b0, 1'b1, stop);
    wr_data = b;
    wr_valid = 1'b1;
    while (!wr_ready) next_cycle();
    next_cycle();
    wr_valid = 1'b0;
    while (!cmd_ready) next_cycle();
endtask

task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
        $display("test %s: ok", cur_test);
    end else begin
        tests_failed++;
        $display("test %s: %0d mismatches", cur_test, test_errors);
    end
    test_errors = 0;
endtask

// read bytes are checked on their handshake
always @(negedge clk) begin
    if (!rst && rd_valid && rd_ready) begin
        check_val("read data", exp_read(rd_idx), rd.data);
        check_val("read last", exp_last, rd.last);
        if (rd_idx < exp_wr_cnt) begin
            rd_idx++;
        end
    end
    if (!rst && missed_ack) begin
        miss_cnt++;
    end
end

always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("Simulation failed");
        $finish;
    end
end

initial begin
    logic [7:0]  b;
    int          wr0, stops0, rstarts0;
    void'($urandom(32'h9db407ac));
    rst = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    wr_data = '0;
    wr_valid = 1'b0;
    rd_ready = 1'b1;
    prescale = prescale_w'(prescale_val);
    stretch_len = '0;
    exp_wr_cnt = 0;
    rd_idx = 0;
    miss_cnt = 0;
    cycles = 0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    exp_last = 1'b0;

    cur_test = "after reset";
    repeat (5) next_cycle();
    check_val("reset outputs", 8'b00000011, {cmd_ready, wr_ready, rd_valid, bus_active,
              bus_control, missed_ack, scl_o, sda_o});
    end_test();
    rst = 1'b0;

    cur_test = "write with stop";
    b = 8'($urandom);
    write_xfer(7'h50, 1'b1, b);
    exp_wr[exp_wr_cnt] = b;
    exp_wr_cnt++;
    check_val("write store count", exp_wr_cnt, slave_i.wr_cnt);
    check_val("write store byte", b, slave_i.mem[0]);
    check_val("write missed_ack", 0, miss_cnt);
    check_val("write starts", 1, slave_i.start_cnt);
    check_val("write stops", 1, slave_i.stop_cnt);
    check_val("write bus idle", 2'b00, {bus_active, bus_control});
    end_test();

    cur_test = "absent slave";
    wr0 = slave_i.wr_cnt;
    write_xfer(7'h23, 1'b1, 8'($urandom));
    check_val("absent missed_ack", 1, miss_cnt);
    check_val("absent store count", wr0, slave_i.wr_cnt);
    end_test();

    cur_test = "repeated start read";
    stops0 = slave_i.stop_cnt;
    rstarts0 = slave_i.rstart_cnt;
    b = 8'($urandom);
    write_xfer(7'h50, 1'b0, b);
    exp_wr[exp_wr_cnt] = b;
    exp_wr_cnt++;
    check_val("held write stops", stops0, slave_i.stop_cnt);
    exp_last = 1'b1;
    send_cmd(7'h50, 1'b0, 1'b1, 1'b0, 1'b1);
    while (!rd_valid) next_cycle();
    while (!cmd_ready) next_cycle();
    check_val("repeated starts", rstarts0 + 1, slave_i.rstart_cnt);
    check_val("read stops", stops0 + 1, slave_i.stop_cnt);
    check_val("reads taken", 1, rd_idx);
    end_test();

    cur_test = "held read then stop";
    rd_ready = 1'b0;
    exp_last = 1'b0;
    send_cmd(7'h50, 1'b0, 1'b1, 1'b0, 1'b0);
    while (!rd_valid) next_cycle();
    repeat (50) begin
        next_cycle();
        check_val("held read state", 4'b1011,
                  {rd_valid, cmd_ready, bus_active, bus_control});
    end
    rd_ready = 1'b1;
    send_cmd(7'h00, 1'b0, 1'b0, 1'b0, 1'b1);
    while (!cmd_ready) next_cycle();
    check_val("held reads taken", 2, rd_idx);
    check_val("held bus_active", 0, bus_active);
    end_test();

    cur_test = "clock stretch";
    stretch_len = 8'd20;
    wr0 = slave_i.wr_cnt;
    b = 8'($urandom);
    write_xfer(7'h50, 1'b1, b);
    stretch_len = '0;
    exp_wr[exp_wr_cnt] = b;
    exp_wr_cnt++;
    check_val("stretches seen", 1, slave_i.stretches);
    check_val("stretched byte", b, slave_i.mem[wr0]);
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire
